//--- Makefile
VERILATOR  ?= verilator
TOP        := pe_tb
FILELIST   := pe_top.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/pe_tb.sv
`timescale 1ns/10ps

module pe_tb;

    localparam int PROG_LEN   = 1024;
    localparam int SEQ_LEN    = 1256;
    localparam int WB_TIMEOUT = 200;
    localparam int WB_LATENCY = 3;

    logic              clk;
    logic              rst_n_i;
    pe_pkg::instr_t    instr_i;
    pe_pkg::pc_t       instr_addr_o;
    logic              wb_valid_o;
    pe_pkg::bank_t     wb_bank_o;
    pe_pkg::reg_addr_t wb_addr_o;
    pe_pkg::mask_t     wb_mask_o;
    pe_pkg::vec_t      data_o;

    int             seed = 71927;
    pe_pkg::instr_t prog_mem [PROG_LEN];
    pe_pkg::vec_t   model_regs [2][32];
    logic [5:0]     prev_dst [2];
    // expected writebacks in program order where dst packs {mask, addr, bank}
    pe_pkg::vec_t   exp_data [$];
    logic [9:0]     exp_dst [$];
    int             exp_test [$];
    int             exp_idx [$];
    int             test_checks [7];
    int             test_errors [7];
    int             total_checks;
    int             total_errors;
    bit             timed_out;

    pe_top #(
        .NUM_REGS (32)
    ) i_pe_top (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .instr_i      (instr_i),
        .instr_addr_o (instr_addr_o),
        .wb_valid_o   (wb_valid_o),
        .wb_bank_o    (wb_bank_o),
        .wb_addr_o    (wb_addr_o),
        .wb_mask_o    (wb_mask_o),
        .data_o       (data_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // the instruction memory answers the fetch address before the next rising edge
    initial begin
        instr_i = '0;
        forever begin
            @(negedge clk);
            instr_i <= prog_mem[instr_addr_o];
        end
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic int test_of(int n);
        if (n < 16) return 1;
        if (n < 64) return 2;
        if (n < 128) return 3;
        if (n < 192) return 4;
        if (n < 256) return 5;
        return 6;
    endfunction

    function automatic string test_name(int t);
        case (t)
            1: return "reset and zero registers";
            2: return "movi with write mask";
            3: return "swizzle, abs and negate";
            4: return "max, min and saturate";
            5: return "dependent instructions";
            default: return "long random program";
        endcase
    endfunction

    task automatic build_program();
        pe_pkg::instr_t w;
        logic [31:0]    r;
        logic [2:0]     opc;
        int             t;
        prev_dst[0] = '0;
        prev_dst[1] = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            w = {rand32(), rand32(), rand32(), rand32()};
            r = rand32();
            t = test_of(i);
            if (t == 1) begin
                opc = (i < 4) ? 3'd0 : 3'd1;
            end else if (t == 2) begin
                opc = i[0] ? 3'd1 : 3'd4;
            end else if (t == 3) begin
                opc = 3'd1;
            end else if (t == 4) begin
                opc = (r[3:0] < 4'd4) ? 3'd4 : {2'b01, r[4]};
            end else if (t == 5) begin
                opc = (r[5:4] == 2'd0) ? 3'd4 : {1'b0, r[5:4]};
            end else if (r[3:0] < 4'd3) begin
                // opcodes 5 to 7 are undefined and behave as NOP
                opc = (r[5:4] == 2'd0) ? 3'd0 : {1'b1, r[5:4]};
            end else begin
                opc = (r[3:0] < 4'd6) ? 3'd4 : (r[3:0] < 4'd9) ? 3'd1 : {2'b01, r[4]};
            end
            w[pe_pkg::OPC_LO +: 3] = opc;
            // reuse a recent destination to hit forwarding and write-through
            for (int k = 0; k < 2; k++) begin
                if (t == 5 || (t >= 3 && r[8 + k])) begin
                    w[pe_pkg::OPND1_LO + k * pe_pkg::OPND_W +: 6] = prev_dst[r[10 + k]];
                end
            end
            if (t <= 3) begin
                w[pe_pkg::SAT_BIT] = 1'b0;
            end
            if (t <= 2) begin
                w[pe_pkg::OPND1_LO + pe_pkg::OPND_NEG] = 1'b0;
                w[pe_pkg::OPND1_LO + pe_pkg::OPND_ABS] = 1'b0;
            end
            if (t == 1 || (t == 2 && opc == 3'd1)) begin
                w[pe_pkg::MASK_LO +: 4] = 4'hF;
            end
            if (t == 2 && opc == 3'd1) begin
                w[pe_pkg::OPND1_LO +: 6] = prev_dst[0];
                w[pe_pkg::OPND1_LO + pe_pkg::OPND_SWZ_LO +: 8] = 8'hE4;
            end
            if (t == 5 && w[pe_pkg::MASK_LO +: 4] == 4'hF) begin
                w[pe_pkg::MASK_LO + r[13:12]] = 1'b0;
            end
            prev_dst[1] = prev_dst[0];
            prev_dst[0] = w[pe_pkg::DST_BANK +: 6];
            prog_mem[i] = w;
        end
    endtask

    function automatic pe_pkg::vec_t operand(pe_pkg::vec_t raw, logic [15:0] f);
        pe_pkg::vec_t  v;
        pe_pkg::lane_t x;
        for (int l = 0; l < 4; l++) begin
            x = raw[32 * f[pe_pkg::OPND_SWZ_LO + 2 * l +: 2] +: 32];
            x[31] = f[pe_pkg::OPND_NEG] ^ (x[31] & !f[pe_pkg::OPND_ABS]);
            v[32 * l +: 32] = x;
        end
        return v;
    endfunction

    // -0 maps to -1 and +0 to 0, so integer order gives sign-magnitude order
    function automatic logic signed [33:0] order_key(pe_pkg::lane_t x);
        return x[31] ? -$signed({3'b0, x[30:0]}) - 34'sd1 : $signed({3'b0, x[30:0]});
    endfunction

    task automatic run_model();
        pe_pkg::instr_t w;
        logic [15:0]    f1;
        logic [15:0]    f2;
        logic [5:0]     dst;
        logic [3:0]     mask;
        logic [2:0]     op;
        pe_pkg::vec_t   a;
        pe_pkg::vec_t   b;
        pe_pkg::vec_t   res;
        pe_pkg::lane_t  x;
        for (int bk = 0; bk < 2; bk++) begin
            for (int r = 0; r < 32; r++) begin
                model_regs[bk][r] = '0;
            end
        end
        for (int n = 0; n < SEQ_LEN; n++) begin
            w = prog_mem[n % PROG_LEN];
            op = w[pe_pkg::OPC_LO +: 3];
            f1 = w[pe_pkg::OPND1_LO +: 16];
            f2 = w[pe_pkg::OPND2_LO +: 16];
            dst = w[pe_pkg::DST_BANK +: 6];
            mask = w[pe_pkg::MASK_LO +: 4];
            a = operand(model_regs[f1[0]][f1[5:1]], f1);
            b = operand(model_regs[f2[0]][f2[5:1]], f2);
            for (int l = 0; l < 4; l++) begin
                case (op)
                    3'd1: x = a[32 * l +: 32];
                    3'd2: x = (order_key(a[32 * l +: 32]) >= order_key(b[32 * l +: 32])) ?
                              a[32 * l +: 32] : b[32 * l +: 32];
                    3'd3: x = (order_key(a[32 * l +: 32]) <= order_key(b[32 * l +: 32])) ?
                              a[32 * l +: 32] : b[32 * l +: 32];
                    default: x = w[pe_pkg::IMM_LO +: 32];
                endcase
                if (w[pe_pkg::SAT_BIT]) begin
                    x = x[31] ? 32'h0 : ((x > pe_pkg::ONE_F) ? pe_pkg::ONE_F : x);
                end
                res[32 * l +: 32] = x;
            end
            if (op >= 3'd1 && op <= 3'd4) begin
                for (int l = 0; l < 4; l++) begin
                    if (mask[l]) begin
                        model_regs[dst[0]][dst[5:1]][32 * l +: 32] = res[32 * l +: 32];
                    end
                end
                exp_data.push_back(res);
                exp_dst.push_back({mask, dst});
                exp_test.push_back(test_of(n));
                exp_idx.push_back(n);
            end
        end
    endtask

    task automatic wait_writeback(output bit expired, output int idle);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (wb_valid_o !== 1'b1 && cycles < WB_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        expired = (wb_valid_o !== 1'b1);
        idle = cycles;
    endtask

    task automatic check_value(string name, int t, logic [31:0] expv, logic [31:0] got);
        test_checks[t]++;
        total_checks++;
        if (got !== expv) begin
            test_errors[t]++;
            total_errors++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, expv, got);
        end
    endtask

    initial begin
        int t;
        int gap;
        int exp_gap;
        rst_n_i = 1'b0;
        total_checks = 0;
        total_errors = 0;
        timed_out = 1'b0;
        for (int i = 0; i < 7; i++) begin
            test_checks[i] = 0;
            test_errors[i] = 0;
        end
        build_program();
        run_model();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        for (int k = 0; k < exp_data.size(); k++) begin
            wait_writeback(timed_out, gap);
            if (timed_out) begin
                $display("timeout: writeback %0d (test %0d) never arrived", k, exp_test[k]);
                break;
            end
            t = exp_test[k];
            // the strobe stays low for NOPs and the first result follows the pipeline latency
            if (k == 0) begin
                exp_gap = exp_idx[0] + WB_LATENCY;
            end else begin
                exp_gap = exp_idx[k] - exp_idx[k - 1] - 1;
            end
            check_value("wb_valid_o idle cycles", t, 32'(exp_gap), 32'(gap));
            check_value("wb_bank_o", t, 32'(exp_dst[k][0]), 32'(wb_bank_o));
            check_value("wb_addr_o", t, 32'(exp_dst[k][5:1]), 32'(wb_addr_o));
            check_value("wb_mask_o", t, 32'(exp_dst[k][9:6]), 32'(wb_mask_o));
            for (int l = 0; l < 4; l++) begin
                if (exp_dst[k][6 + l]) begin
                    check_value($sformatf("data_o lane %0d", l), t, exp_data[k][32 * l +: 32],
                                data_o[32 * l +: 32]);
                end
            end
            if (k == exp_data.size() - 1 || exp_test[k + 1] != t) begin
                $display("test %0d %s: %0d checks, %0d errors", t, test_name(t),
                         test_checks[t], test_errors[t]);
            end
        end
        $display("total: %0d checks, %0d errors", total_checks, total_errors);
        if (!timed_out && total_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- bench/pe_tb_assert.sv
`timescale 1ns/10ps

module pe_tb_assert (
    input logic              clk,
    input logic              rst_n_i,
    input pe_pkg::pc_t       instr_addr_i,
    input logic              wb_valid_i,
    input pe_pkg::bank_t     wb_bank_i,
    input pe_pkg::reg_addr_t wb_addr_i,
    input pe_pkg::mask_t     wb_mask_i,
    input pe_pkg::vec_t      data_i
);

    // every reset edge clears the writeback strobe
    assert property (@(posedge clk) !rst_n_i |=> !wb_valid_i)
        else $error("wb_valid_o high after a reset edge");

    // the fetch address moves by one at every edge out of reset
    assert property (@(posedge clk)
        $past(rst_n_i) |-> instr_addr_i == pe_pkg::pc_t'($past(instr_addr_i) + 1'b1))
        else $error("instr_addr_o did not advance by one");

    assert property (@(posedge clk)
        wb_valid_i |-> !$isunknown({wb_bank_i, wb_addr_i, wb_mask_i, data_i}))
        else $error("writeback outputs unknown while wb_valid_o is high");

endmodule

bind pe_top pe_tb_assert i_pe_tb_assert (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .instr_addr_i (instr_addr_o),
    .wb_valid_i   (wb_valid_o),
    .wb_bank_i    (wb_bank_o),
    .wb_addr_i    (wb_addr_o),
    .wb_mask_i    (wb_mask_o),
    .data_i       (data_o)
);

//--- common/pe_pkg.sv
package pe_pkg;

    // lane and vector geometry
    localparam int LANES  = 4;
    localparam int LANE_W = 32;

    typedef logic [LANE_W-1:0]       lane_t;
    typedef logic [LANES*LANE_W-1:0] vec_t;
    typedef logic [127:0]            instr_t;
    typedef logic [9:0]              pc_t;
    typedef logic [4:0]              reg_addr_t;

    // 0 selects the parameter bank and 1 the temporary bank
    typedef logic [0:0]              bank_t;
    typedef logic [LANES-1:0]        mask_t;

    // output lane i takes the source lane named by bits 2i+1..2i
    typedef logic [2*LANES-1:0]      swizzle_t;

    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,
        OP_MOV  = 3'd1,
        OP_MAX  = 3'd2,
        OP_MIN  = 3'd3,
        OP_MOVI = 3'd4
    } op_e;

    // instruction word layout
    localparam int OPC_LO      = 0;
    localparam int DST_BANK    = 3;
    localparam int DST_ADDR_LO = 4;
    localparam int MASK_LO     = 9;
    localparam int SAT_BIT     = 13;
    localparam int OPND1_LO    = 16;
    localparam int OPND2_LO    = 32;
    localparam int OPND_W      = 16;
    localparam int IMM_LO      = 96;

    // layout inside one 16-bit operand field
    localparam int OPND_BANK    = 0;
    localparam int OPND_ADDR_LO = 1;
    localparam int OPND_NEG     = 6;
    localparam int OPND_ABS     = 7;
    localparam int OPND_SWZ_LO  = 8;

    // 1.0 in single precision is the upper saturation bound
    localparam lane_t ONE_F = 32'h3F80_0000;

endpackage

//--- common/stage_if.sv
`timescale 1ns/10ps

interface stage_if;

    logic              valid;
    pe_pkg::op_e       op;
    logic              sat;
    pe_pkg::bank_t     dst_bank;
    pe_pkg::reg_addr_t dst_addr;
    pe_pkg::mask_t     mask;
    pe_pkg::bank_t     op1_bank;
    pe_pkg::reg_addr_t op1_addr;
    logic              op1_neg;
    logic              op1_abs;
    pe_pkg::swizzle_t  op1_swz;
    pe_pkg::bank_t     op2_bank;
    pe_pkg::reg_addr_t op2_addr;
    logic              op2_neg;
    logic              op2_abs;
    pe_pkg::swizzle_t  op2_swz;
    pe_pkg::lane_t     imm;

    modport dec (output valid, op, sat, dst_bank, dst_addr, mask, op1_bank, op1_addr,
                 op1_neg, op1_abs, op1_swz, op2_bank, op2_addr, op2_neg, op2_abs, op2_swz, imm);
    modport rf (input op1_bank, op1_addr, op2_bank, op2_addr);
    modport ex (input valid, op, sat, dst_bank, dst_addr, mask, op1_bank, op1_addr,
                op1_neg, op1_abs, op1_swz, op2_bank, op2_addr, op2_neg, op2_abs, op2_swz, imm);

endinterface

//--- common/wb_if.sv
`timescale 1ns/10ps

interface wb_if;

    logic              valid;
    pe_pkg::bank_t     bank;
    pe_pkg::reg_addr_t addr;
    pe_pkg::mask_t     mask;
    pe_pkg::vec_t      data;

    // execute drives the bus from its writeback register
    modport src (output valid, bank, addr, mask, data);

    // register file write port
    modport rf (input valid, bank, addr, mask, data);

    // forwarding into the operand units
    modport fwd (input valid, bank, addr, mask, data);

endinterface

//--- decode/pe_decoder.sv
`timescale 1ns/10ps

module pe_decoder (
    input  logic           clk,
    input  logic           rst_n_i,
    input  pe_pkg::instr_t instr_i,
    output pe_pkg::pc_t    instr_addr_o,
    stage_if.dec           stage
);

    pe_pkg::pc_t                 pc_q;
    pe_pkg::instr_t              instr_d_q;
    pe_pkg::op_e                 op_d;
    logic [pe_pkg::OPND_W-1:0]   opnd1_d;
    logic [pe_pkg::OPND_W-1:0]   opnd2_d;

    // no stalls exist, so the program counter moves every cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_q + 1'b1;
        end
    end

    assign instr_addr_o = pc_q;

    // a cleared fetch register holds opcode 0, which reads as a NOP
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            instr_d_q <= '0;
        end else begin
            instr_d_q <= instr_i;
        end
    end

    always_comb begin
        case (instr_d_q[pe_pkg::OPC_LO +: $bits(pe_pkg::op_e)])
            pe_pkg::OP_MOV, pe_pkg::OP_MAX, pe_pkg::OP_MIN, pe_pkg::OP_MOVI: begin
                op_d = pe_pkg::op_e'(instr_d_q[pe_pkg::OPC_LO +: $bits(pe_pkg::op_e)]);
            end
            default: begin
                op_d = pe_pkg::OP_NOP;
            end
        endcase
    end

    assign opnd1_d = instr_d_q[pe_pkg::OPND1_LO +: pe_pkg::OPND_W];
    assign opnd2_d = instr_d_q[pe_pkg::OPND2_LO +: pe_pkg::OPND_W];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            stage.valid <= 1'b0;
            stage.op    <= pe_pkg::OP_NOP;
        end else begin
            stage.valid <= (op_d != pe_pkg::OP_NOP);
            stage.op    <= op_d;
        end
    end

    always_ff @(posedge clk) begin
        stage.sat      <= instr_d_q[pe_pkg::SAT_BIT];
        stage.dst_bank <= instr_d_q[pe_pkg::DST_BANK];
        stage.dst_addr <= instr_d_q[pe_pkg::DST_ADDR_LO +: $bits(pe_pkg::reg_addr_t)];
        stage.mask     <= instr_d_q[pe_pkg::MASK_LO +: pe_pkg::LANES];
        stage.op1_bank <= opnd1_d[pe_pkg::OPND_BANK];
        stage.op1_addr <= opnd1_d[pe_pkg::OPND_ADDR_LO +: $bits(pe_pkg::reg_addr_t)];
        stage.op1_neg  <= opnd1_d[pe_pkg::OPND_NEG];
        stage.op1_abs  <= opnd1_d[pe_pkg::OPND_ABS];
        stage.op1_swz  <= opnd1_d[pe_pkg::OPND_SWZ_LO +: $bits(pe_pkg::swizzle_t)];
        stage.op2_bank <= opnd2_d[pe_pkg::OPND_BANK];
        stage.op2_addr <= opnd2_d[pe_pkg::OPND_ADDR_LO +: $bits(pe_pkg::reg_addr_t)];
        stage.op2_neg  <= opnd2_d[pe_pkg::OPND_NEG];
        stage.op2_abs  <= opnd2_d[pe_pkg::OPND_ABS];
        stage.op2_swz  <= opnd2_d[pe_pkg::OPND_SWZ_LO +: $bits(pe_pkg::swizzle_t)];
        stage.imm      <= instr_d_q[pe_pkg::IMM_LO +: pe_pkg::LANE_W];
    end

endmodule

//--- execute/pe_execute.sv
`timescale 1ns/10ps

module pe_execute (
    input  logic         clk,
    input  logic         rst_n_i,
    stage_if.ex          stage,
    input  pe_pkg::vec_t rd1_data_i,
    input  pe_pkg::vec_t rd2_data_i,
    wb_if.src            wb
);

    logic              ex_valid_q;
    pe_pkg::op_e       ex_op_q;
    logic              ex_sat_q;
    pe_pkg::bank_t     ex_dst_bank_q;
    pe_pkg::reg_addr_t ex_dst_addr_q;
    pe_pkg::mask_t     ex_mask_q;
    pe_pkg::bank_t     ex_op1_bank_q;
    pe_pkg::bank_t     ex_op2_bank_q;
    pe_pkg::reg_addr_t ex_op1_addr_q;
    pe_pkg::reg_addr_t ex_op2_addr_q;
    logic              ex_op1_neg_q;
    logic              ex_op2_neg_q;
    logic              ex_op1_abs_q;
    logic              ex_op2_abs_q;
    pe_pkg::swizzle_t  ex_op1_swz_q;
    pe_pkg::swizzle_t  ex_op2_swz_q;
    pe_pkg::lane_t     ex_imm_q;
    pe_pkg::vec_t      ex_rd1_q;
    pe_pkg::vec_t      ex_rd2_q;
    pe_pkg::vec_t      opnd1;
    pe_pkg::vec_t      opnd2;
    pe_pkg::vec_t      result;

    // sign-magnitude order, so -0 sorts below +0
    function automatic logic lane_less(input pe_pkg::lane_t a, input pe_pkg::lane_t b);
        logic less;
        if (a[pe_pkg::LANE_W-1] != b[pe_pkg::LANE_W-1]) begin
            less = a[pe_pkg::LANE_W-1];
        end else if (a[pe_pkg::LANE_W-1]) begin
            less = a[pe_pkg::LANE_W-2:0] > b[pe_pkg::LANE_W-2:0];
        end else begin
            less = a[pe_pkg::LANE_W-2:0] < b[pe_pkg::LANE_W-2:0];
        end
        return less;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_valid_q <= 1'b0;
        end else begin
            ex_valid_q <= stage.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_op_q       <= stage.op;
        ex_sat_q      <= stage.sat;
        ex_dst_bank_q <= stage.dst_bank;
        ex_dst_addr_q <= stage.dst_addr;
        ex_mask_q     <= stage.mask;
        ex_op1_bank_q <= stage.op1_bank;
        ex_op2_bank_q <= stage.op2_bank;
        ex_op1_addr_q <= stage.op1_addr;
        ex_op2_addr_q <= stage.op2_addr;
        ex_op1_neg_q  <= stage.op1_neg;
        ex_op2_neg_q  <= stage.op2_neg;
        ex_op1_abs_q  <= stage.op1_abs;
        ex_op2_abs_q  <= stage.op2_abs;
        ex_op1_swz_q  <= stage.op1_swz;
        ex_op2_swz_q  <= stage.op2_swz;
        ex_imm_q      <= stage.imm;
        ex_rd1_q      <= rd1_data_i;
        ex_rd2_q      <= rd2_data_i;
    end

    // the operand units watch the writeback register through their own view of the bus
    wb_if wb_fwd ();

    assign wb_fwd.valid = wb.valid;
    assign wb_fwd.bank  = wb.bank;
    assign wb_fwd.addr  = wb.addr;
    assign wb_fwd.mask  = wb.mask;
    assign wb_fwd.data  = wb.data;

    pe_operand_unit i_opnd1 (
        .rd_data_i (ex_rd1_q),
        .bank_i    (ex_op1_bank_q),
        .addr_i    (ex_op1_addr_q),
        .negate_i  (ex_op1_neg_q),
        .abs_i     (ex_op1_abs_q),
        .swizzle_i (ex_op1_swz_q),
        .wb        (wb_fwd.fwd),
        .opnd_o    (opnd1)
    );

    pe_operand_unit i_opnd2 (
        .rd_data_i (ex_rd2_q),
        .bank_i    (ex_op2_bank_q),
        .addr_i    (ex_op2_addr_q),
        .negate_i  (ex_op2_neg_q),
        .abs_i     (ex_op2_abs_q),
        .swizzle_i (ex_op2_swz_q),
        .wb        (wb_fwd.fwd),
        .opnd_o    (opnd2)
    );

    always_comb begin
        pe_pkg::lane_t a;
        pe_pkg::lane_t b;
        pe_pkg::lane_t r;
        for (int l = 0; l < pe_pkg::LANES; l++) begin
            a = opnd1[l*pe_pkg::LANE_W +: pe_pkg::LANE_W];
            b = opnd2[l*pe_pkg::LANE_W +: pe_pkg::LANE_W];
            case (ex_op_q)
                pe_pkg::OP_MAX:  r = lane_less(a, b) ? b : a;
                pe_pkg::OP_MIN:  r = lane_less(a, b) ? a : b;
                pe_pkg::OP_MOVI: r = ex_imm_q;
                default:         r = a;
            endcase
            // saturation clamps to [0.0, 1.0] and sends negatives including -0 to zero
            if (ex_sat_q) begin
                if (r[pe_pkg::LANE_W-1]) begin
                    r = '0;
                end else if (r > pe_pkg::ONE_F) begin
                    r = pe_pkg::ONE_F;
                end
            end
            result[l*pe_pkg::LANE_W +: pe_pkg::LANE_W] = r;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= ex_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        wb.bank <= ex_dst_bank_q;
        wb.addr <= ex_dst_addr_q;
        wb.mask <= ex_mask_q;
        wb.data <= result;
    end

endmodule

//--- execute/pe_operand_unit.sv
`timescale 1ns/10ps

module pe_operand_unit (
    input  pe_pkg::vec_t      rd_data_i,
    input  pe_pkg::bank_t     bank_i,
    input  pe_pkg::reg_addr_t addr_i,
    input  logic              negate_i,
    input  logic              abs_i,
    input  pe_pkg::swizzle_t  swizzle_i,
    wb_if.fwd                 wb,
    output pe_pkg::vec_t      opnd_o
);

    logic         hit;
    pe_pkg::vec_t fwd_data;

    // the instruction just ahead is still in writeback and has not reached the banks
    assign hit = wb.valid && (wb.bank == bank_i) && (wb.addr == addr_i);

    always_comb begin
        for (int l = 0; l < pe_pkg::LANES; l++) begin
            if (hit && wb.mask[l]) begin
                fwd_data[l*pe_pkg::LANE_W +: pe_pkg::LANE_W] =
                    wb.data[l*pe_pkg::LANE_W +: pe_pkg::LANE_W];
            end else begin
                fwd_data[l*pe_pkg::LANE_W +: pe_pkg::LANE_W] =
                    rd_data_i[l*pe_pkg::LANE_W +: pe_pkg::LANE_W];
            end
        end
    end

    // swizzle first, then abs clears the sign and negate flips it
    always_comb begin
        pe_pkg::lane_t lane;
        for (int l = 0; l < pe_pkg::LANES; l++) begin
            lane = fwd_data[pe_pkg::LANE_W*swizzle_i[2*l +: 2] +: pe_pkg::LANE_W];
            if (abs_i) begin
                lane[pe_pkg::LANE_W-1] = 1'b0;
            end
            if (negate_i) begin
                lane[pe_pkg::LANE_W-1] = ~lane[pe_pkg::LANE_W-1];
            end
            opnd_o[l*pe_pkg::LANE_W +: pe_pkg::LANE_W] = lane;
        end
    end

endmodule

//--- pe_top.f
common/pe_pkg.sv
common/stage_if.sv
common/wb_if.sv
decode/pe_decoder.sv
regfile/pe_reg_file.sv
execute/pe_operand_unit.sv
execute/pe_execute.sv
verilog/pe_top.sv
bench/pe_tb_assert.sv
bench/pe_tb.sv

//--- regfile/pe_reg_file.sv
`timescale 1ns/10ps

module pe_reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic         clk,
    input  logic         rst_n_i,
    stage_if.rf          stage,
    wb_if.rf             wb,
    output pe_pkg::vec_t rd1_data_o,
    output pe_pkg::vec_t rd2_data_o
);

    localparam int AW = $clog2(NUM_REGS);

    pe_pkg::vec_t      regs_q [2][NUM_REGS];
    pe_pkg::vec_t      wr_old;
    pe_pkg::vec_t      wr_merged;
    pe_pkg::bank_t     rd_bank [2];
    pe_pkg::reg_addr_t rd_addr [2];
    pe_pkg::vec_t      rd_data [2];

    // lanes outside the mask keep their stored value
    always_comb begin
        wr_old = regs_q[wb.bank][wb.addr[AW-1:0]];
        for (int l = 0; l < pe_pkg::LANES; l++) begin
            wr_merged[l*pe_pkg::LANE_W +: pe_pkg::LANE_W] = wb.mask[l] ?
                wb.data[l*pe_pkg::LANE_W +: pe_pkg::LANE_W] :
                wr_old[l*pe_pkg::LANE_W +: pe_pkg::LANE_W];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int b = 0; b < 2; b++) begin
                for (int r = 0; r < NUM_REGS; r++) begin
                    regs_q[b][r] <= '0;
                end
            end
        end else if (wb.valid) begin
            regs_q[wb.bank][wb.addr[AW-1:0]] <= wr_merged;
        end
    end

    assign rd_bank[0] = stage.op1_bank;
    assign rd_addr[0] = stage.op1_addr;
    assign rd_bank[1] = stage.op2_bank;
    assign rd_addr[1] = stage.op2_addr;

    // a read of the register being written sees the merged value this cycle
    for (genvar p = 0; p < 2; p++) begin : g_rd
        always_comb begin
            if (wb.valid && wb.bank == rd_bank[p] && wb.addr == rd_addr[p]) begin
                rd_data[p] = wr_merged;
            end else begin
                rd_data[p] = regs_q[rd_bank[p]][rd_addr[p][AW-1:0]];
            end
        end
    end

    assign rd1_data_o = rd_data[0];
    assign rd2_data_o = rd_data[1];

endmodule

//--- verilog/pe_top.sv
`timescale 1ns/10ps

module pe_top #(
    parameter int NUM_REGS = 32
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  pe_pkg::instr_t    instr_i,
    output pe_pkg::pc_t       instr_addr_o,
    output logic              wb_valid_o,
    output pe_pkg::bank_t     wb_bank_o,
    output pe_pkg::reg_addr_t wb_addr_o,
    output pe_pkg::mask_t     wb_mask_o,
    output pe_pkg::vec_t      data_o
);

    pe_pkg::vec_t rd1_data;
    pe_pkg::vec_t rd2_data;

    stage_if stage ();
    wb_if    wb ();

    pe_decoder i_pe_decoder (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .instr_i      (instr_i),
        .instr_addr_o (instr_addr_o),
        .stage        (stage.dec)
    );

    pe_reg_file #(
        .NUM_REGS (NUM_REGS)
    ) i_pe_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .stage      (stage.rf),
        .wb         (wb.rf),
        .rd1_data_o (rd1_data),
        .rd2_data_o (rd2_data)
    );

    pe_execute i_pe_execute (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .stage      (stage.ex),
        .rd1_data_i (rd1_data),
        .rd2_data_i (rd2_data),
        .wb         (wb.src)
    );

    // the writeback bus is also the external result port
    assign wb_valid_o = wb.valid;
    assign wb_bank_o  = wb.bank;
    assign wb_addr_o  = wb.addr;
    assign wb_mask_o  = wb.mask;
    assign data_o     = wb.data;

endmodule
